// ==== tb.f ====
rtl/calcPkg.sv
rtl/tickGen.sv
rtl/calcCtrl.sv
rtl/mulDivUnit.sv
rtl/calcAlu.sv
rtl/segSerializer.sv
rtl/calcTop.sv
sim/calcTop_chk.sv
sim/calcTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/100ps -j 0
TOP       := calcTb
FILELIST  := tb.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))
RUN_ARGS  := +verilator+error+limit+100

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM) $(RUN_ARGS))"; echo "$$out"; \
	echo "$$out" | grep -q "^TESTS PASSED$$"

clean:
	rm -rf $(OBJ_DIR)

// ==== sim/calcTb.sv ====
`timescale 1ns/100ps
`default_nettype none

module calcTb;
	import calcPkg::*;

	localparam int WAIT_LIMIT = 4 * FRAME_DIV;

	logic        clk;
	logic        rstN;
	logic [15:0] sw;
	logic        btn;
	wire         segClk;
	wire         segSout;
	wire         segPen;
	wire         segClrn;
	logic [31:0] lfsrState = 32'hed8c;
	logic [31:0] modelA = '0;
	logic [31:0] modelB = '0;
	int          errCount = 0;
	int          testCount = 0;
	// Frame monitor
	logic [63:0] shiftBits = '0;
	logic        prevClk = 1'b0;
	logic        prevPen = 1'b0;
	logic [32:0] frameWord = '0;
	int          framesStarted = 0;
	int          framesDone = 0;

	calcTop dut_i (
		.clk       (clk),
		.i_rstN    (rstN),
		.i_sw      (sw),
		.i_btn     (btn),
		.o_segClk  (segClk),
		.o_segSout (segSout),
		.o_segPen  (segPen),
		.o_segClrn (segClrn)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Bit 32 flags a byte that is no hex digit
	function automatic logic [32:0] decodeFrame(input logic [63:0] bits);
		logic [32:0] res;
		logic        found;
		res = '0;
		for (int d = 0; d < 8; d++) begin
			found = 1'b0;
			for (int n = 0; n < 16; n++) begin
				if (hexToSeg(4'(n)) == bits[d*8 +: 8]) begin
					res[d*4 +: 4] = 4'(n);
					found = 1'b1;
				end
			end
			if (!found)
				res[32] = 1'b1;
		end
		return res;
	endfunction

	always @(posedge clk) begin
		prevClk <= segClk;
		prevPen <= segPen;
		if (segPen && !prevPen)
			framesStarted <= framesStarted + 1;
		if (segClk && !prevClk && segPen)
			shiftBits <= {shiftBits[62:0], segSout};
		if (prevPen && !segPen) begin
			frameWord  <= decodeFrame(shiftBits);
			framesDone <= framesDone + 1;
		end
	end

	////////////////////////////////////////////////////////////
	// Reference model and random operands
	////////////////////////////////////////////////////////////
	function automatic logic [63:0] expectedResult(input logic [4:0] op,
		input logic [31:0] a, input logic [31:0] b);
		logic [4:0]  sh;
		logic [31:0] fill;
		sh   = b[4:0];
		fill = a[31] ? ~(32'hFFFFFFFF >> sh) : 32'h0;
		case (op)
			OP_ADD:  return 64'(a) + 64'(b);
			OP_SUB:  return 64'(a) - 64'(b);
			OP_AND:  return {32'b0, a & b};
			OP_OR:   return {32'b0, a | b};
			OP_XOR:  return {32'b0, a ^ b};
			OP_NOT:  return {32'b0, ~a};
			OP_SHL:  return {32'b0, a << sh};
			OP_SHR:  return {32'b0, a >> sh};
			OP_SAR:  return {32'b0, (a >> sh) | fill};
			OP_MUL:  return 64'(a) * 64'(b);
			OP_DIV:  return (b == 0) ? {32'b0, 32'hFFFFFFFF} : {32'b0, a / b};
			OP_MOD:  return (b == 0) ? {32'b0, a} : {32'b0, a % b};
			default: return 64'd0;
		endcase
	endfunction

	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic randomWord(output logic [31:0] w);
		w = '0;
		for (int i = 0; i < 32; i++) begin
			lfsrState = lfsrNext(lfsrState);
			w = {w[30:0], lfsrState[0]};
		end
	endtask

	// Low for three sample periods, then high for three
	task automatic pressButton();
		for (int i = 0; i < 6 * SAMPLE_DIV; i++) begin
			@(posedge clk);
			btn <= (i >= 3 * SAMPLE_DIV);
		end
		@(posedge clk);
		btn <= 1'b0;
	endtask

	task automatic pressAt(input logic isB, input int k, input int n);
		@(posedge clk);
		sw[15]    <= isB;
		sw[12:10] <= 3'(k);
		repeat (n) pressButton();
		if (isB)
			modelB[k*4 +: 4] = modelB[k*4 +: 4] + 4'(n);
		else
			modelA[k*4 +: 4] = modelA[k*4 +: 4] + 4'(n);
	endtask

	task automatic enterOperand(input logic isB, input logic [31:0] target);
		logic [31:0] cur;
		logic [3:0]  steps;
		for (int k = 0; k < 8; k++) begin
			cur   = isB ? modelB : modelA;
			steps = target[k*4 +: 4] - cur[k*4 +: 4];
			pressAt(isB, k, int'(steps));
		end
	endtask

	task automatic setOpcode(input logic [4:0] op);
		@(posedge clk);
		sw[4:0] <= op;
	endtask

	// Second frame to start after the select change
	task automatic readWord(input logic [1:0] sel, output logic [31:0] word);
		int startMark;
		int waited;
		@(posedge clk);
		sw[14:13] <= sel;
		repeat (2) @(posedge clk);
		startMark = framesStarted;
		waited    = 0;
		word      = '0;
		while (framesDone < startMark + 2 && waited < WAIT_LIMIT) begin
			@(posedge clk);
			waited++;
		end
		if (waited >= WAIT_LIMIT) begin
			$display("Timeout: no display frame finished at %0t", $time);
			$display("TESTS FAILED");
			$finish;
		end else begin
			assert (!frameWord[32]) else begin
				$display("ERR %0t: frame holds a segment byte that is no hex digit", $time);
				errCount++;
			end
			word = frameWord[31:0];
		end
	endtask

	task automatic checkWord(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp) else begin
			$display("ERR %0t: %s shows %08h, expected %08h", $time, what, got, exp);
			errCount++;
		end
	endtask

	task automatic readResult(input logic [4:0] op);
		logic [63:0] exp;
		logic [31:0] got;
		exp = expectedResult(op, modelA, modelB);
		readWord(DISP_LO, got);
		checkWord($sformatf("op %0d low half", op), got, exp[31:0]);
		readWord(DISP_HI, got);
		checkWord($sformatf("op %0d high half", op), got, exp[63:32]);
	endtask

	task automatic waitStart();
		int waited;
		waited = 0;
		do begin
			@(posedge clk);
			waited++;
		end while (!dut_i.aluStart && waited < 16);
		if (!dut_i.aluStart) begin
			$display("Timeout: the ALU start strobe never came");
			$display("TESTS FAILED");
			$finish;
		end
	endtask

	task automatic finishTest(input string name, input int errsBefore);
		testCount++;
		if (errCount == errsBefore)
			$display("test %s: pass", name);
		else
			$display("test %s: fail with %0d errors", name, errCount - errsBefore);
	endtask

	////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////
	initial begin
		logic [31:0] got;
		logic [31:0] randA;
		logic [31:0] randB;
		int          mark;
		rstN = 1'b0;
		sw   = '0;
		btn  = 1'b0;
		repeat (10) @(posedge clk);
		rstN <= 1'b1;

		mark = errCount;
		for (int s = 0; s < 4; s++) begin
			readWord(2'(s), got);
			checkWord($sformatf("selector %0d after reset", s), got, 32'h0);
		end
		assert (segClrn === 1'b1) else begin
			$display("ERR %0t: segment clear still low after reset", $time);
			errCount++;
		end
		finishTest("reset", mark);

		// 17 presses wrap to 1
		mark = errCount;
		pressAt(1'b0, 3, 5);
		pressAt(1'b1, 6, 17);
		readWord(DISP_A, got);
		checkWord("operand A", got, modelA);
		readWord(DISP_B, got);
		checkWord("operand B", got, modelB);
		finishTest("button entry", mark);

		mark = errCount;
		randomWord(randA);
		randomWord(randB);
		enterOperand(1'b0, randA);
		enterOperand(1'b1, randB);
		for (int op = 0; op <= 8; op++) begin
			setOpcode(5'(op));
			readResult(5'(op));
		end
		finishTest("single-cycle ops", mark);

		mark = errCount;
		for (int op = 9; op <= 11; op++) begin
			setOpcode(5'(op));
			readResult(5'(op));
		end
		enterOperand(1'b1, 32'h0);
		setOpcode(OP_DIV);
		readResult(OP_DIV);
		setOpcode(OP_MOD);
		readResult(OP_MOD);
		finishTest("multiply and divide", mark);

		// Switch away while the multiply is still running
		mark = errCount;
		setOpcode(OP_MUL);
		waitStart();
		sw[4:0] <= OP_NOT;
		readResult(OP_NOT);
		finishTest("relaunch", mark);

		errCount += dut_i.calcTopChk_i.clkFails + dut_i.calcTopChk_i.startFails
			+ dut_i.calcTopChk_i.doneFails;
		$display("%0d tests run, %0d errors", testCount, errCount);
		if (errCount == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim/calcTop_chk.sv ====
`timescale 1ns/100ps
`default_nettype none

module calcTopChk (
	input wire clk,
	input wire i_rstN,
	input wire i_segClk,
	input wire i_segPen,
	input wire i_start,
	input wire i_done
);
	logic       busy;
	logic [5:0] waitCnt;
	int         clkFails = 0;
	int         startFails = 0;
	int         doneFails = 0;

	// Run in flight from start until its done
	always_ff @(posedge clk) begin
		if (!i_rstN) begin
			busy    <= 1'b0;
			waitCnt <= '0;
		end else if (i_start) begin
			busy    <= 1'b1;
			waitCnt <= '0;
		end else if (busy) begin
			waitCnt <= waitCnt + 1'b1;
			if (i_done)
				busy <= 1'b0;
		end
	end

	////////////////////////////////////////////////////////////
	// Display link and ALU handshake
	////////////////////////////////////////////////////////////
	segClkInFrame: assert property (@(posedge clk) disable iff (!i_rstN)
		$rose(i_segClk) |-> i_segPen)
	else begin
		clkFails++;
		$error("segment clock rose while the frame enable was low");
	end

	startWhileIdle: assert property (@(posedge clk) disable iff (!i_rstN)
		i_start |-> !busy)
	else begin
		startFails++;
		$error("ALU start issued while a run was still outstanding");
	end

	// Done no later than 34 cycles after start
	doneInTime: assert property (@(posedge clk) disable iff (!i_rstN)
		busy |-> (waitCnt < 6'd34))
	else begin
		doneFails++;
		$error("ALU done did not arrive within 34 cycles of start");
	end

endmodule

bind calcTop calcTopChk calcTopChk_i (
	.clk      (clk),
	.i_rstN   (i_rstN),
	.i_segClk (o_segClk),
	.i_segPen (o_segPen),
	.i_start  (aluStart),
	.i_done   (aluDone)
);

`default_nettype wire

// ==== rtl/calcTop.sv ====
`timescale 1ns/100ps
`default_nettype none

module calcTop (
	input  wire        clk,
	input  wire        i_rstN,
	input  wire [15:0] i_sw,
	input  wire        i_btn,
	output wire        o_segClk,
	output wire        o_segSout,
	output wire        o_segPen,
	output wire        o_segClrn
);
	import calcPkg::*;

	logic        sampleTick;
	logic        frameTick;
	logic [31:0] opA;
	logic [31:0] opB;
	logic [4:0]  aluOpcode;
	logic        aluStart;
	logic        aluDone;
	resultWord_t aluResult;
	resultWord_t dispResult;

	tickGen tickGen_i (
		.clk          (clk),
		.i_rstN       (i_rstN),
		.o_sampleTick (sampleTick),
		.o_frameTick  (frameTick)
	);

	// sw[15] operand, sw[12:10] digit, sw[4:0] opcode
	calcCtrl calcCtrl_i (
		.clk          (clk),
		.i_rstN       (i_rstN),
		.i_sampleTick (sampleTick),
		.i_btn        (i_btn),
		.i_opSel      (i_sw[15]),
		.i_digitIdx   (i_sw[12:10]),
		.i_opcode     (i_sw[4:0]),
		.i_done       (aluDone),
		.i_result     (aluResult),
		.o_opA        (opA),
		.o_opB        (opB),
		.o_opcode     (aluOpcode),
		.o_start      (aluStart),
		.o_result     (dispResult)
	);

	calcAlu calcAlu_i (
		.clk      (clk),
		.i_rstN   (i_rstN),
		.i_start  (aluStart),
		.i_opA    (opA),
		.i_opB    (opB),
		.i_opcode (aluOpcode),
		.o_done   (aluDone),
		.o_result (aluResult)
	);

	// sw[14:13] picks the shown word
	segSerializer segSerializer_i (
		.clk         (clk),
		.i_rstN      (i_rstN),
		.i_frameTick (frameTick),
		.i_dispSel   (i_sw[14:13]),
		.i_opA       (opA),
		.i_opB       (opB),
		.i_result    (dispResult),
		.o_segClk    (o_segClk),
		.o_segSout   (o_segSout),
		.o_segPen    (o_segPen),
		.o_segClrn   (o_segClrn)
	);

endmodule

`default_nettype wire

// ==== rtl/segSerializer.sv ====
`timescale 1ns/100ps
`default_nettype none

module segSerializer (
	input  wire                       clk,
	input  wire                       i_rstN,
	input  wire                       i_frameTick,
	input  wire  [1:0]                i_dispSel,
	input  wire  [31:0]               i_opA,
	input  wire  [31:0]               i_opB,
	input  wire calcPkg::resultWord_t i_result,
	output logic                      o_segClk,
	output logic                      o_segSout,
	output logic                      o_segPen,
	output logic                      o_segClrn
);
	import calcPkg::*;

	logic [31:0]          dispWord;
	logic [SEG_BITS-1:0]  pattern;
	logic [SEG_BITS-1:0]  shiftReg;
	logic [SEG_CNT_W-1:0] bitCnt;
	logic                 phase;
	logic                 tail;

	// Word to show, then one segment byte per digit, MSD on top
	always_comb begin
		case (i_dispSel)
			DISP_A:  dispWord = i_opA;
			DISP_B:  dispWord = i_opB;
			DISP_LO: dispWord = i_result.half.lo;
			DISP_HI: dispWord = i_result.half.hi;
		endcase
		for (int d = 0; d < 8; d++) begin
			pattern[d*8 +: 8] = hexToSeg(dispWord[d*4 +: 4]);
		end
	end

	////////////////////////////////////////////////////////////
	// Serial link, two cycles per bit, MSB first
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (!i_rstN) begin
			o_segClk  <= 1'b0;
			o_segSout <= 1'b0;
			o_segPen  <= 1'b0;
			o_segClrn <= 1'b0;
			bitCnt    <= '0;
			phase     <= 1'b0;
			tail      <= 1'b0;
		end else begin
			o_segClrn <= 1'b1;
			if (!o_segPen) begin
				// Ticks during a shift are dropped
				if (i_frameTick) begin
					shiftReg  <= pattern;
					o_segSout <= pattern[SEG_BITS-1];
					o_segPen  <= 1'b1;
					bitCnt    <= '0;
					phase     <= 1'b0;
				end
			end else if (tail) begin
				o_segPen <= 1'b0;
				tail     <= 1'b0;
			end else if (!phase) begin
				o_segClk <= 1'b1;
				phase    <= 1'b1;
			end else begin
				o_segClk <= 1'b0;
				phase    <= 1'b0;
				if (bitCnt == SEG_CNT_W'(SEG_BITS - 1)) begin
					tail <= 1'b1;
				end else begin
					bitCnt    <= bitCnt + 1'b1;
					shiftReg  <= shiftReg << 1;
					o_segSout <= shiftReg[SEG_BITS-2];
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== rtl/calcAlu.sv ====
`timescale 1ns/100ps
`default_nettype none

module calcAlu (
	input  wire                  clk,
	input  wire                  i_rstN,
	input  wire                  i_start,
	input  wire  [31:0]          i_opA,
	input  wire  [31:0]          i_opB,
	input  wire  [4:0]           i_opcode,
	output logic                 o_done,
	output calcPkg::resultWord_t o_result
);
	import calcPkg::*;

	logic        isMulDiv;
	logic        mdStart;
	logic [4:0]  opQ;
	logic [63:0] scNext;
	logic [63:0] scResult;
	logic        scDone;
	logic        mdDone;
	logic [63:0] product;
	logic [31:0] quotient;
	logic [31:0] remainder;

	assign isMulDiv = (i_opcode == OP_MUL) || (i_opcode == OP_DIV) || (i_opcode == OP_MOD);
	assign mdStart  = i_start && isMulDiv;

	// Single-cycle operations; 32-bit results are zero-extended
	always_comb begin
		case (i_opcode)
			OP_ADD:  scNext = {32'b0, i_opA} + {32'b0, i_opB};
			OP_SUB:  scNext = {32'b0, i_opA} - {32'b0, i_opB};
			OP_AND:  scNext = {32'b0, i_opA & i_opB};
			OP_OR:   scNext = {32'b0, i_opA | i_opB};
			OP_XOR:  scNext = {32'b0, i_opA ^ i_opB};
			OP_NOT:  scNext = {32'b0, ~i_opA};
			OP_SHL:  scNext = {32'b0, i_opA << i_opB[4:0]};
			OP_SHR:  scNext = {32'b0, i_opA >> i_opB[4:0]};
			OP_SAR:  scNext = {32'b0, $signed(i_opA) >>> i_opB[4:0]};
			default: scNext = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!i_rstN) begin
			scDone <= 1'b0;
			opQ    <= OP_ADD;
		end else begin
			scDone <= i_start && !isMulDiv;
			if (i_start)
				opQ <= i_opcode;
		end
	end

	always_ff @(posedge clk) begin
		if (i_start)
			scResult <= scNext;
	end

	mulDivUnit mulDivUnit_i (
		.clk         (clk),
		.i_rstN      (i_rstN),
		.i_start     (mdStart),
		.i_isDiv     (i_opcode != OP_MUL),
		.i_opA       (i_opA),
		.i_opB       (i_opB),
		.o_done      (mdDone),
		.o_product   (product),
		.o_quotient  (quotient),
		.o_remainder (remainder)
	);

	// Only one of the two paths is ever in flight
	assign o_done = scDone | mdDone;

	always_comb begin
		case (opQ)
			OP_MUL:  o_result.word = product;
			OP_DIV:  o_result.word = {32'b0, quotient};
			OP_MOD:  o_result.word = {32'b0, remainder};
			default: o_result.word = scResult;
		endcase
	end

endmodule

`default_nettype wire

// ==== rtl/mulDivUnit.sv ====
`timescale 1ns/100ps
`default_nettype none

module mulDivUnit (
	input  wire         clk,
	input  wire         i_rstN,
	input  wire         i_start,
	input  wire         i_isDiv,
	input  wire  [31:0] i_opA,
	input  wire  [31:0] i_opB,
	output logic        o_done,
	output logic [63:0] o_product,
	output logic [31:0] o_quotient,
	output logic [31:0] o_remainder
);
	logic [63:0] acc;
	logic [63:0] accNext;
	logic [31:0] operand;
	logic        isDiv;
	logic        running;
	logic        finish;
	logic [4:0]  stepCnt;
	logic [32:0] mulSum;
	logic [33:0] divTrial;

	////////////////////////////////////////////////////////////
	// One step of either algorithm
	////////////////////////////////////////////////////////////
	// Multiply: add multiplicand into the high half, shift right
	// Divide: shift left, subtract divisor if it fits, shift in the quotient bit
	always_comb begin
		mulSum   = {1'b0, acc[63:32]} + (acc[0] ? {1'b0, operand} : 33'd0);
		divTrial = {1'b0, acc[63:31]} - {2'b00, operand};
		if (!isDiv)
			accNext = {mulSum, acc[31:1]};
		else if (!divTrial[33])
			accNext = {divTrial[31:0], acc[30:0], 1'b1};
		else
			accNext = {acc[62:0], 1'b0};
	end

	// 32 steps, one idle cycle, then done
	always_ff @(posedge clk) begin
		if (!i_rstN) begin
			running <= 1'b0;
			finish  <= 1'b0;
			o_done  <= 1'b0;
			stepCnt <= '0;
		end else begin
			finish <= running && (stepCnt == 5'd31);
			o_done <= finish;
			if (i_start) begin
				running <= 1'b1;
				stepCnt <= '0;
			end else if (running) begin
				stepCnt <= stepCnt + 1'b1;
				if (stepCnt == 5'd31)
					running <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (i_start) begin
			acc     <= {32'b0, i_isDiv ? i_opA : i_opB};
			operand <= i_isDiv ? i_opB : i_opA;
			isDiv   <= i_isDiv;
		end else if (running) begin
			acc <= accNext;
		end
	end

	// Accumulator holds still between runs
	assign o_product   = acc;
	assign o_quotient  = acc[31:0];
	assign o_remainder = acc[63:32];

endmodule

`default_nettype wire

// ==== rtl/calcCtrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module calcCtrl (
	input  wire                       clk,
	input  wire                       i_rstN,
	input  wire                       i_sampleTick,
	input  wire                       i_btn,
	input  wire                       i_opSel,
	input  wire  [2:0]                i_digitIdx,
	input  wire  [4:0]                i_opcode,
	input  wire                       i_done,
	input  wire calcPkg::resultWord_t i_result,
	output logic [31:0]               o_opA,
	output logic [31:0]               o_opB,
	output logic [4:0]                o_opcode,
	output logic                      o_start,
	output calcPkg::resultWord_t      o_result
);
	import calcPkg::*;

	logic [3:0]  btnHist;
	logic        press;
	logic [1:0]  state;
	logic [31:0] lastA;
	logic [31:0] lastB;
	logic        pending;
	logic        changed;

	////////////////////////////////////////////////////////////
	// Button debounce and digit entry
	////////////////////////////////////////////////////////////
	// Two low samples then two high samples count as one press
	assign press = i_sampleTick && ({btnHist[2:0], i_btn} == 4'b0011);

	always_ff @(posedge clk) begin
		if (!i_rstN) begin
			btnHist <= '0;
			o_opA   <= '0;
			o_opB   <= '0;
		end else begin
			if (i_sampleTick)
				btnHist <= {btnHist[2:0], i_btn};
			if (press && i_opSel)
				o_opB[{i_digitIdx, 2'b00} +: 4] <= o_opB[{i_digitIdx, 2'b00} +: 4] + 4'd1;
			else if (press)
				o_opA[{i_digitIdx, 2'b00} +: 4] <= o_opA[{i_digitIdx, 2'b00} +: 4] + 4'd1;
		end
	end

	////////////////////////////////////////////////////////////
	// Launch FSM
	////////////////////////////////////////////////////////////
	// o_opcode holds the opcode of the run in flight
	assign changed = (o_opA != lastA) || (o_opB != lastB) || (i_opcode != o_opcode);
	assign o_start = (state == ST_LAUNCH);

	always_ff @(posedge clk) begin
		if (!i_rstN) begin
			state    <= ST_IDLE;
			lastA    <= '0;
			lastB    <= '0;
			o_opcode <= OP_ADD;
			pending  <= 1'b0;
			o_result <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (changed) begin
						lastA    <= o_opA;
						lastB    <= o_opB;
						o_opcode <= i_opcode;
						state    <= ST_LAUNCH;
					end
				end
				ST_LAUNCH: begin
					state <= ST_BUSY;
				end
				default: begin
					// Remember edits made while the ALU is working
					if (changed)
						pending <= 1'b1;
					if (i_done) begin
						o_result <= i_result;
						if (pending || changed) begin
							lastA    <= o_opA;
							lastB    <= o_opB;
							o_opcode <= i_opcode;
							pending  <= 1'b0;
							state    <= ST_LAUNCH;
						end else begin
							state <= ST_IDLE;
						end
					end
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== rtl/tickGen.sv ====
`timescale 1ns/100ps
`default_nettype none

module tickGen (
	input  wire  clk,
	input  wire  i_rstN,
	output logic o_sampleTick,
	output logic o_frameTick
);
	import calcPkg::*;

	logic [SAMPLE_W-1:0] sampleCnt;
	logic [FRAME_W-1:0]  frameCnt;

	// Button sampling strobe
	always_ff @(posedge clk) begin
		if (!i_rstN) begin
			sampleCnt    <= '0;
			o_sampleTick <= 1'b0;
		end else if (sampleCnt == SAMPLE_W'(SAMPLE_DIV - 1)) begin
			sampleCnt    <= '0;
			o_sampleTick <= 1'b1;
		end else begin
			sampleCnt    <= sampleCnt + 1'b1;
			o_sampleTick <= 1'b0;
		end
	end

	// Display refresh strobe, slower than one full frame shift
	always_ff @(posedge clk) begin
		if (!i_rstN) begin
			frameCnt    <= '0;
			o_frameTick <= 1'b0;
		end else if (frameCnt == FRAME_W'(FRAME_DIV - 1)) begin
			frameCnt    <= '0;
			o_frameTick <= 1'b1;
		end else begin
			frameCnt    <= frameCnt + 1'b1;
			o_frameTick <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/calcPkg.sv ====
`default_nettype none

package calcPkg;

	////////////////////////////////////////////////////////////
	// Operation codes on i_sw[4:0]
	////////////////////////////////////////////////////////////
	localparam logic [4:0] OP_ADD = 5'd0;
	localparam logic [4:0] OP_SUB = 5'd1;
	localparam logic [4:0] OP_AND = 5'd2;
	localparam logic [4:0] OP_OR  = 5'd3;
	localparam logic [4:0] OP_XOR = 5'd4;
	localparam logic [4:0] OP_NOT = 5'd5;
	localparam logic [4:0] OP_SHL = 5'd6;
	localparam logic [4:0] OP_SHR = 5'd7;
	localparam logic [4:0] OP_SAR = 5'd8;
	localparam logic [4:0] OP_MUL = 5'd9;
	localparam logic [4:0] OP_DIV = 5'd10;
	localparam logic [4:0] OP_MOD = 5'd11;

	// Display word on i_sw[14:13]
	localparam logic [1:0] DISP_A  = 2'd0;
	localparam logic [1:0] DISP_B  = 2'd1;
	localparam logic [1:0] DISP_LO = 2'd2;
	localparam logic [1:0] DISP_HI = 2'd3;

	// Timing, in clock cycles
	localparam int SAMPLE_DIV = 16;
	localparam int SAMPLE_W   = $clog2(SAMPLE_DIV);
	localparam int FRAME_DIV  = 512;
	localparam int FRAME_W    = $clog2(FRAME_DIV);
	localparam int SEG_BITS   = 64;
	localparam int SEG_CNT_W  = $clog2(SEG_BITS);

	// Controller states
	localparam logic [1:0] ST_IDLE   = 2'd0;
	localparam logic [1:0] ST_LAUNCH = 2'd1;
	localparam logic [1:0] ST_BUSY   = 2'd2;

	// 64-bit result, seen whole or as two halves
	typedef union packed {
		logic [63:0] word;
		struct packed {
			logic [31:0] hi;
			logic [31:0] lo;
		} half;
	} resultWord_t;

	// Active low {dp, g, f, e, d, c, b, a}, dp always dark
	function automatic logic [7:0] hexToSeg(input logic [3:0] digit);
		logic [7:0] seg;
		case (digit)
			4'h0: seg = 8'hC0;
			4'h1: seg = 8'hF9;
			4'h2: seg = 8'hA4;
			4'h3: seg = 8'hB0;
			4'h4: seg = 8'h99;
			4'h5: seg = 8'h92;
			4'h6: seg = 8'h82;
			4'h7: seg = 8'hF8;
			4'h8: seg = 8'h80;
			4'h9: seg = 8'h90;
			4'hA: seg = 8'h88;
			4'hB: seg = 8'h83;
			4'hC: seg = 8'hC6;
			4'hD: seg = 8'hA1;
			4'hE: seg = 8'h86;
			default: seg = 8'h8E;
		endcase
		return seg;
	endfunction

endpackage

`default_nettype wire
